/* src/udp_echo_pkg.sv */
// ----------------------------------------------------------
// Types and constants shared by the serial and UDP echo paths
// ----------------------------------------------------------
package udp_echo_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;

    // Header fields needed to build an echo reply
    typedef struct packed {
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        udp_port_t   src_port;
        udp_port_t   dst_port;
        logic [15:0] length;
        logic [7:0]  ttl;
        logic [15:0] checksum;
    } udp_hdr_t;

    // Payload handling for the frame in progress
    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        DROP
    } filter_state_e;

    localparam udp_port_t ECHO_PORT = 16'd1234;
    localparam ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [7:0] REPLY_TTL = 8'd64;

    // 200 MHz / 115200 baud
    localparam int UART_CLKS_PER_BIT = 1736;

    localparam int UART_FIFO_DEPTH = 256;
    localparam int PAYLOAD_FIFO_DEPTH = 2048;

endpackage

/* src/byte_stream_if.sv */
// ----------------------------------------------------------
// Byte stream with valid/ready handshake plus last and user
// ----------------------------------------------------------
interface byte_stream_if;
    import udp_echo_pkg::*;

    byte_t tdata;
    logic  tvalid;
    logic  tready;
    logic  tlast;
    logic  tuser;

    modport source (
        output tdata,
        output tvalid,
        output tlast,
        output tuser,
        input  tready
    );

    modport sink (
        input  tdata,
        input  tvalid,
        input  tlast,
        input  tuser,
        output tready
    );

endinterface

/* src/byte_fifo.sv */
// ----------------------------------------------------------
// First-word-fall-through byte FIFO, DEPTH a power of two
// ----------------------------------------------------------
module byte_fifo #(
    parameter int DEPTH = 16
) (
    input  logic clk,
    input  logic rst,
    byte_stream_if.sink   i_in,
    byte_stream_if.source i_out
);
    import udp_echo_pkg::*;

    localparam int AW = $clog2(DEPTH);

    typedef struct packed {
        logic  user;
        logic  last;
        byte_t data;
    } entry_t;

    entry_t        mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   level;
    logic          wr_en;
    logic          rd_en;

    assign i_in.tready  = (level != (AW + 1)'(DEPTH));
    assign i_out.tvalid = (level != '0);

    // Output shows the head entry directly
    assign i_out.tdata = mem[rd_ptr].data;
    assign i_out.tlast = mem[rd_ptr].last;
    assign i_out.tuser = mem[rd_ptr].user;

    assign wr_en = i_in.tvalid && i_in.tready;
    assign rd_en = i_out.tvalid && i_out.tready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= '{user: i_in.tuser, last: i_in.tlast, data: i_in.tdata};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                level <= level + 1'b1;
            end else if (rd_en && !wr_en) begin
                level <= level - 1'b1;
            end
        end
    end

endmodule

/* src/uart_rx.sv */
// ----------------------------------------------------------
// 8N1 UART receiver, one tvalid strobe per good frame
// ----------------------------------------------------------
module uart_rx #(
    parameter int CLKS_PER_BIT = 1736
) (
    input  logic clk,
    input  logic rst,
    input  logic i_rxd,
    byte_stream_if.source o_byte
);
    import udp_echo_pkg::*;

    localparam int CW = $clog2(CLKS_PER_BIT);

    logic [1:0]    rxd_sync;
    logic          rxd;
    logic          busy;
    logic [CW-1:0] baud_cnt;
    logic [3:0]    bit_idx;
    logic          strobe;
    byte_t         shift;
    logic          sample;

    assign rxd    = rxd_sync[1];
    assign sample = busy && (baud_cnt == '0);

    // Line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_sync <= 2'b11;
        end else begin
            rxd_sync <= {rxd_sync[0], i_rxd};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            strobe   <= 1'b0;
        end else begin
            strobe <= 1'b0;
            if (!busy) begin
                if (!rxd) begin
                    // First sample lands mid start bit
                    busy     <= 1'b1;
                    bit_idx  <= '0;
                    baud_cnt <= CW'(CLKS_PER_BIT / 2 - 1);
                end
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt <= CW'(CLKS_PER_BIT - 1);
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && rxd) begin
                    // Start bit gone by mid-bit, treat as a glitch
                    busy <= 1'b0;
                end else if (bit_idx == 4'd9) begin
                    busy   <= 1'b0;
                    strobe <= rxd;
                end
            end
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            shift <= {rxd, shift[7:1]};
        end
    end

    assign o_byte.tdata  = shift;
    assign o_byte.tvalid = strobe;
    assign o_byte.tlast  = 1'b0;
    assign o_byte.tuser  = 1'b0;

endmodule

/* src/uart_tx.sv */
// ----------------------------------------------------------
// 8N1 UART transmitter, pulls one byte whenever it is idle
// ----------------------------------------------------------
module uart_tx #(
    parameter int CLKS_PER_BIT = 1736
) (
    input  logic clk,
    input  logic rst,
    byte_stream_if.sink i_byte,
    output logic o_txd
);
    localparam int CW = $clog2(CLKS_PER_BIT);

    logic          idle;
    logic          txd;
    logic [8:0]    shift;
    logic [3:0]    bits_left;
    logic [CW-1:0] baud_cnt;
    logic          accept;
    logic          next_bit;

    assign i_byte.tready = idle;
    assign o_txd         = txd;

    assign accept   = idle && i_byte.tvalid;
    assign next_bit = !idle && (baud_cnt == '0) && (bits_left != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            idle      <= 1'b1;
            txd       <= 1'b1;
            bits_left <= '0;
            baud_cnt  <= '0;
        end else if (idle) begin
            if (i_byte.tvalid) begin
                // Start bit goes out on the next cycle
                idle      <= 1'b0;
                txd       <= 1'b0;
                bits_left <= 4'd9;
                baud_cnt  <= CW'(CLKS_PER_BIT - 1);
            end
        end else if (baud_cnt != '0) begin
            baud_cnt <= baud_cnt - 1'b1;
        end else if (bits_left == '0) begin
            // Stop bit period done
            idle <= 1'b1;
        end else begin
            txd       <= shift[0];
            bits_left <= bits_left - 1'b1;
            baud_cnt  <= CW'(CLKS_PER_BIT - 1);
        end
    end

    // Eight data bits then the stop bit, LSB first
    always_ff @(posedge clk) begin
        if (accept) begin
            shift <= {1'b1, i_byte.tdata};
        end else if (next_bit) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

/* src/udp_port_filter.sv */
// ----------------------------------------------------------
// Matches the UDP destination port at the header handshake
// and forwards or drops the payload; builds the reply header
// ----------------------------------------------------------
module udp_port_filter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_hdr_valid,
    output logic                   o_hdr_ready,
    input  udp_echo_pkg::ip_addr_t  i_src_ip,
    input  udp_echo_pkg::ip_addr_t  i_dst_ip,
    input  udp_echo_pkg::udp_port_t i_src_port,
    input  udp_echo_pkg::udp_port_t i_dst_port,
    input  logic [15:0]            i_length,
    input  udp_echo_pkg::byte_t     i_payload_tdata,
    input  logic                   i_payload_tvalid,
    input  logic                   i_payload_tlast,
    input  logic                   i_payload_tuser,
    output logic                   o_rx_tready,
    byte_stream_if.source          o_payload,
    output logic                   o_reply_valid,
    input  logic                   i_reply_ready,
    output udp_echo_pkg::udp_hdr_t  o_reply
);
    import udp_echo_pkg::*;

    filter_state_e state;
    logic          hdr_xfer;
    logic          last_xfer;

    // Held off while the previous reply header is still pending
    assign o_hdr_ready = (state == IDLE) && !o_reply_valid;
    assign hdr_xfer    = i_hdr_valid && o_hdr_ready;
    assign last_xfer   = i_payload_tvalid && o_rx_tready && i_payload_tlast;

    assign o_payload.tdata  = i_payload_tdata;
    assign o_payload.tvalid = i_payload_tvalid && (state == FORWARD);
    assign o_payload.tlast  = i_payload_tlast;
    assign o_payload.tuser  = i_payload_tuser;

    // Dropped bytes are accepted and thrown away
    assign o_rx_tready = ((state == FORWARD) && o_payload.tready) || (state == DROP);

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            o_reply_valid <= 1'b0;
        end else begin
            if (o_reply_valid && i_reply_ready) begin
                o_reply_valid <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (hdr_xfer) begin
                        if (i_dst_port == ECHO_PORT) begin
                            state         <= FORWARD;
                            o_reply_valid <= 1'b1;
                        end else begin
                            state <= DROP;
                        end
                    end
                end
                FORWARD, DROP: begin
                    if (last_xfer) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Reply goes back to the sender from the local address
    always_ff @(posedge clk) begin
        if (hdr_xfer && i_dst_port == ECHO_PORT) begin
            o_reply.src_ip   <= LOCAL_IP;
            o_reply.dst_ip   <= i_src_ip;
            o_reply.src_port <= i_dst_port;
            o_reply.dst_port <= i_src_port;
            o_reply.length   <= i_length;
            o_reply.ttl      <= REPLY_TTL;
            o_reply.checksum <= '0;
        end
    end

endmodule

/* src/udp_echo_path.sv */
// ----------------------------------------------------------
// UDP echo: port filter, payload FIFO and LED capture of the
// first byte of each echoed frame
// ----------------------------------------------------------
module udp_echo_path (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_hdr_valid,
    output logic                   o_hdr_ready,
    input  udp_echo_pkg::ip_addr_t  i_src_ip,
    input  udp_echo_pkg::ip_addr_t  i_dst_ip,
    input  udp_echo_pkg::udp_port_t i_src_port,
    input  udp_echo_pkg::udp_port_t i_dst_port,
    input  logic [15:0]            i_length,
    input  udp_echo_pkg::byte_t     i_payload_tdata,
    input  logic                   i_payload_tvalid,
    input  logic                   i_payload_tlast,
    input  logic                   i_payload_tuser,
    output logic                   o_rx_tready,
    output logic                   o_reply_valid,
    input  logic                   i_reply_ready,
    output udp_echo_pkg::udp_hdr_t  o_reply,
    output udp_echo_pkg::byte_t     o_tx_tdata,
    output logic                   o_tx_tvalid,
    output logic                   o_tx_tlast,
    output logic                   o_tx_tuser,
    input  logic                   i_tx_tready,
    output udp_echo_pkg::byte_t     o_led
);
    import udp_echo_pkg::*;

    byte_stream_if fifo_in ();
    byte_stream_if fifo_out ();

    logic in_frame;

    udp_port_filter u_filter (
        .clk              (clk),
        .rst              (rst),
        .i_hdr_valid      (i_hdr_valid),
        .o_hdr_ready      (o_hdr_ready),
        .i_src_ip         (i_src_ip),
        .i_dst_ip         (i_dst_ip),
        .i_src_port       (i_src_port),
        .i_dst_port       (i_dst_port),
        .i_length         (i_length),
        .i_payload_tdata  (i_payload_tdata),
        .i_payload_tvalid (i_payload_tvalid),
        .i_payload_tlast  (i_payload_tlast),
        .i_payload_tuser  (i_payload_tuser),
        .o_rx_tready      (o_rx_tready),
        .o_payload        (fifo_in),
        .o_reply_valid    (o_reply_valid),
        .i_reply_ready    (i_reply_ready),
        .o_reply          (o_reply)
    );

    byte_fifo #(
        .DEPTH (PAYLOAD_FIFO_DEPTH)
    ) u_payload_fifo (
        .clk   (clk),
        .rst   (rst),
        .i_in  (fifo_in),
        .i_out (fifo_out)
    );

    assign o_tx_tdata      = fifo_out.tdata;
    assign o_tx_tvalid     = fifo_out.tvalid;
    assign o_tx_tlast      = fifo_out.tlast;
    assign o_tx_tuser      = fifo_out.tuser;
    assign fifo_out.tready = i_tx_tready;

    // Latch the first byte shown after each frame boundary
    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            o_led    <= '0;
        end else begin
            if (o_tx_tvalid && !in_frame) begin
                o_led <= o_tx_tdata;
            end
            if (o_tx_tvalid && i_tx_tready && o_tx_tlast) begin
                in_frame <= 1'b0;
            end else if (o_tx_tvalid) begin
                in_frame <= 1'b1;
            end
        end
    end

endmodule

/* src/echo_core.sv */
// ----------------------------------------------------------
// Top level: UART loopback through a byte FIFO and UDP echo
// on port 1234 over parsed header and payload streams
// ----------------------------------------------------------
module echo_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_uart_rxd,
    output logic                    o_uart_txd,
    output udp_echo_pkg::byte_t      o_led,
    input  logic                    i_rx_hdr_valid,
    output logic                    o_rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t   i_rx_src_ip,
    input  udp_echo_pkg::ip_addr_t   i_rx_dst_ip,
    input  udp_echo_pkg::udp_port_t  i_rx_src_port,
    input  udp_echo_pkg::udp_port_t  i_rx_dst_port,
    input  logic [15:0]             i_rx_length,
    input  udp_echo_pkg::byte_t      i_rx_tdata,
    input  logic                    i_rx_tvalid,
    input  logic                    i_rx_tlast,
    input  logic                    i_rx_tuser,
    output logic                    o_rx_tready,
    output logic                    o_tx_hdr_valid,
    input  logic                    i_tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t   o_tx_src_ip,
    output udp_echo_pkg::ip_addr_t   o_tx_dst_ip,
    output udp_echo_pkg::udp_port_t  o_tx_src_port,
    output udp_echo_pkg::udp_port_t  o_tx_dst_port,
    output logic [15:0]             o_tx_length,
    output logic [7:0]              o_tx_ttl,
    output logic [15:0]             o_tx_checksum,
    output udp_echo_pkg::byte_t      o_tx_tdata,
    output logic                    o_tx_tvalid,
    output logic                    o_tx_tlast,
    output logic                    o_tx_tuser,
    input  logic                    i_tx_tready
);
    import udp_echo_pkg::*;

    byte_stream_if uart_rx_s ();
    byte_stream_if uart_tx_s ();

    udp_hdr_t reply_hdr;

    // Serial echo
    uart_rx #(
        .CLKS_PER_BIT (UART_CLKS_PER_BIT)
    ) u_uart_rx (
        .clk    (clk),
        .rst    (rst),
        .i_rxd  (i_uart_rxd),
        .o_byte (uart_rx_s)
    );

    byte_fifo #(
        .DEPTH (UART_FIFO_DEPTH)
    ) u_uart_fifo (
        .clk   (clk),
        .rst   (rst),
        .i_in  (uart_rx_s),
        .i_out (uart_tx_s)
    );

    uart_tx #(
        .CLKS_PER_BIT (UART_CLKS_PER_BIT)
    ) u_uart_tx (
        .clk    (clk),
        .rst    (rst),
        .i_byte (uart_tx_s),
        .o_txd  (o_uart_txd)
    );

    // UDP echo
    udp_echo_path u_udp_echo (
        .clk              (clk),
        .rst              (rst),
        .i_hdr_valid      (i_rx_hdr_valid),
        .o_hdr_ready      (o_rx_hdr_ready),
        .i_src_ip         (i_rx_src_ip),
        .i_dst_ip         (i_rx_dst_ip),
        .i_src_port       (i_rx_src_port),
        .i_dst_port       (i_rx_dst_port),
        .i_length         (i_rx_length),
        .i_payload_tdata  (i_rx_tdata),
        .i_payload_tvalid (i_rx_tvalid),
        .i_payload_tlast  (i_rx_tlast),
        .i_payload_tuser  (i_rx_tuser),
        .o_rx_tready      (o_rx_tready),
        .o_reply_valid    (o_tx_hdr_valid),
        .i_reply_ready    (i_tx_hdr_ready),
        .o_reply          (reply_hdr),
        .o_tx_tdata       (o_tx_tdata),
        .o_tx_tvalid      (o_tx_tvalid),
        .o_tx_tlast       (o_tx_tlast),
        .o_tx_tuser       (o_tx_tuser),
        .i_tx_tready      (i_tx_tready),
        .o_led            (o_led)
    );

    assign o_tx_src_ip   = reply_hdr.src_ip;
    assign o_tx_dst_ip   = reply_hdr.dst_ip;
    assign o_tx_src_port = reply_hdr.src_port;
    assign o_tx_dst_port = reply_hdr.dst_port;
    assign o_tx_length   = reply_hdr.length;
    assign o_tx_ttl      = reply_hdr.ttl;
    assign o_tx_checksum = reply_hdr.checksum;

endmodule

/* testbench/tb_echo_core.sv */
// ----------------------------------------------------------
// Directed tests of echo_core covering the UART loopback, UDP
// echo on port 1234, dropped frames, LED and back-pressure
// ----------------------------------------------------------
module tb_echo_core;
    timeunit 1ns;
    timeprecision 1ps;
    import udp_echo_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int UART_BYTES = 3;
    localparam int MAX_PAYLOAD = 20;
    localparam int FRAME_COUNT = 5;
    localparam int FRAME_CYCLES = 400;
    // Each UART byte costs one received and one echoed frame
    localparam int UART_TEST_CYCLES = UART_BYTES * 2 * 10 * UART_CLKS_PER_BIT;
    localparam int CYCLE_LIMIT =
        2 * (RESET_CYCLES + UART_TEST_CYCLES + FRAME_COUNT * FRAME_CYCLES);

    // Reply rules for echoed frames
    localparam logic [15:0] EXP_ECHO_PORT = 16'd1234;
    localparam logic [31:0] EXP_LOCAL_IP = 32'hc0a8_0180;
    localparam logic [7:0]  EXP_TTL = 8'd64;

    logic        clk;
    logic        rst;
    logic        i_uart_rxd;
    logic        o_uart_txd;
    byte_t       o_led;
    logic        i_rx_hdr_valid;
    logic        o_rx_hdr_ready;
    ip_addr_t    i_rx_src_ip;
    ip_addr_t    i_rx_dst_ip;
    udp_port_t   i_rx_src_port;
    udp_port_t   i_rx_dst_port;
    logic [15:0] i_rx_length;
    byte_t       i_rx_tdata;
    logic        i_rx_tvalid;
    logic        i_rx_tlast;
    logic        i_rx_tuser;
    logic        o_rx_tready;
    logic        o_tx_hdr_valid;
    logic        i_tx_hdr_ready;
    ip_addr_t    o_tx_src_ip;
    ip_addr_t    o_tx_dst_ip;
    udp_port_t   o_tx_src_port;
    udp_port_t   o_tx_dst_port;
    logic [15:0] o_tx_length;
    logic [7:0]  o_tx_ttl;
    logic [15:0] o_tx_checksum;
    byte_t       o_tx_tdata;
    logic        o_tx_tvalid;
    logic        o_tx_tlast;
    logic        o_tx_tuser;
    logic        i_tx_tready;

    int    errors;
    int    cycle_cnt;
    int    stall_cnt;
    byte_t led_expected;
    byte_t uart_bytes [UART_BYTES];
    byte_t payload [MAX_PAYLOAD];
    logic  payload_user [MAX_PAYLOAD];
    int    payload_len;

    echo_core i_dut (
        .clk            (clk),
        .rst            (rst),
        .i_uart_rxd     (i_uart_rxd),
        .o_uart_txd     (o_uart_txd),
        .o_led          (o_led),
        .i_rx_hdr_valid (i_rx_hdr_valid),
        .o_rx_hdr_ready (o_rx_hdr_ready),
        .i_rx_src_ip    (i_rx_src_ip),
        .i_rx_dst_ip    (i_rx_dst_ip),
        .i_rx_src_port  (i_rx_src_port),
        .i_rx_dst_port  (i_rx_dst_port),
        .i_rx_length    (i_rx_length),
        .i_rx_tdata     (i_rx_tdata),
        .i_rx_tvalid    (i_rx_tvalid),
        .i_rx_tlast     (i_rx_tlast),
        .i_rx_tuser     (i_rx_tuser),
        .o_rx_tready    (o_rx_tready),
        .o_tx_hdr_valid (o_tx_hdr_valid),
        .i_tx_hdr_ready (i_tx_hdr_ready),
        .o_tx_src_ip    (o_tx_src_ip),
        .o_tx_dst_ip    (o_tx_dst_ip),
        .o_tx_src_port  (o_tx_src_port),
        .o_tx_dst_port  (o_tx_dst_port),
        .o_tx_length    (o_tx_length),
        .o_tx_ttl       (o_tx_ttl),
        .o_tx_checksum  (o_tx_checksum),
        .o_tx_tdata     (o_tx_tdata),
        .o_tx_tvalid    (o_tx_tvalid),
        .o_tx_tlast     (o_tx_tlast),
        .o_tx_tuser     (o_tx_tuser),
        .i_tx_tready    (i_tx_tready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: tests still running after %0d cycles", cycle_cnt);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string test, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("ERROR %s: %s expected %0h, actual %0h", test, field, expected, actual);
        errors++;
    endtask

    // Reply-side ready drops low for random stretches when stalling
    function automatic logic next_ready(input bit stall);
        if (!stall) begin
            return 1'b1;
        end
        if (stall_cnt != 0) begin
            stall_cnt--;
            return 1'b0;
        end
        if ($urandom_range(0, 3) == 0) begin
            stall_cnt = $urandom_range(1, 8);
        end
        return 1'b1;
    endfunction

    task automatic send_uart_byte(input byte_t data);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0};
        @(negedge clk);
        for (int k = 0; k < 10; k++) begin
            i_uart_rxd = bits[k];
            repeat (UART_CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    // Samples each bit in its middle starting from the falling start edge
    task automatic capture_uart_byte(output byte_t data, output logic start_bit,
                                     output logic stop_bit);
        while (o_uart_txd !== 1'b0) begin
            @(negedge clk);
        end
        repeat (UART_CLKS_PER_BIT / 2) @(negedge clk);
        start_bit = o_uart_txd;
        for (int k = 0; k < 8; k++) begin
            repeat (UART_CLKS_PER_BIT) @(negedge clk);
            data[k] = o_uart_txd;
        end
        repeat (UART_CLKS_PER_BIT) @(negedge clk);
        stop_bit = o_uart_txd;
    endtask

    task automatic check_reset_state();
        @(posedge clk);
        if (o_tx_hdr_valid !== 1'b0) begin
            report_mismatch("reset", "o_tx_hdr_valid", 0, o_tx_hdr_valid);
        end
        if (o_tx_tvalid !== 1'b0) begin
            report_mismatch("reset", "o_tx_tvalid", 0, o_tx_tvalid);
        end
        if (o_uart_txd !== 1'b1) begin
            report_mismatch("reset", "o_uart_txd", 1, o_uart_txd);
        end
        if (o_led !== 8'h00) begin
            report_mismatch("reset", "o_led", 0, o_led);
        end
        if (o_rx_hdr_ready !== 1'b1) begin
            report_mismatch("reset", "o_rx_hdr_ready", 1, o_rx_hdr_ready);
        end
    endtask

    task automatic test_uart_echo();
        for (int i = 0; i < UART_BYTES; i++) begin
            uart_bytes[i] = byte_t'($urandom);
        end
        fork
            begin
                for (int i = 0; i < UART_BYTES; i++) begin
                    send_uart_byte(uart_bytes[i]);
                end
            end
            begin
                byte_t got;
                logic  start_bit;
                logic  stop_bit;
                for (int j = 0; j < UART_BYTES; j++) begin
                    capture_uart_byte(got, start_bit, stop_bit);
                    if (start_bit !== 1'b0) begin
                        report_mismatch("uart_echo", "start bit", 0, start_bit);
                    end
                    if (got !== uart_bytes[j]) begin
                        report_mismatch("uart_echo", "byte", uart_bytes[j], got);
                    end
                    if (stop_bit !== 1'b1) begin
                        report_mismatch("uart_echo", "stop bit", 1, stop_bit);
                    end
                end
            end
        join
    endtask

    task automatic send_header(input ip_addr_t src_ip, input udp_port_t src_port,
                               input udp_port_t dst_port, input logic [15:0] length);
        @(negedge clk);
        i_rx_hdr_valid = 1'b1;
        i_rx_src_ip    = src_ip;
        i_rx_dst_ip    = EXP_LOCAL_IP;
        i_rx_src_port  = src_port;
        i_rx_dst_port  = dst_port;
        i_rx_length    = length;
        do begin
            @(posedge clk);
        end while (!o_rx_hdr_ready);
        @(negedge clk);
        i_rx_hdr_valid = 1'b0;
    endtask

    task automatic send_payload();
        for (int i = 0; i < payload_len; i++) begin
            @(negedge clk);
            i_rx_tdata  = payload[i];
            i_rx_tvalid = 1'b1;
            i_rx_tlast  = (i == payload_len - 1);
            i_rx_tuser  = payload_user[i];
            do begin
                @(posedge clk);
            end while (!o_rx_tready);
        end
        @(negedge clk);
        i_rx_tvalid = 1'b0;
        i_rx_tlast  = 1'b0;
        i_rx_tuser  = 1'b0;
    endtask

    task automatic collect_reply(input string test, input ip_addr_t src_ip,
                                 input udp_port_t src_port, input logic [15:0] length,
                                 input bit stall);
        bit done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            i_tx_hdr_ready = next_ready(stall);
            @(posedge clk);
            done = o_tx_hdr_valid && i_tx_hdr_ready;
        end
        if (o_tx_src_ip !== EXP_LOCAL_IP) begin
            report_mismatch(test, "src_ip", EXP_LOCAL_IP, o_tx_src_ip);
        end
        if (o_tx_dst_ip !== src_ip) begin
            report_mismatch(test, "dst_ip", src_ip, o_tx_dst_ip);
        end
        if (o_tx_src_port !== EXP_ECHO_PORT) begin
            report_mismatch(test, "src_port", EXP_ECHO_PORT, o_tx_src_port);
        end
        if (o_tx_dst_port !== src_port) begin
            report_mismatch(test, "dst_port", src_port, o_tx_dst_port);
        end
        if (o_tx_length !== length) begin
            report_mismatch(test, "length", length, o_tx_length);
        end
        if (o_tx_ttl !== EXP_TTL) begin
            report_mismatch(test, "ttl", EXP_TTL, o_tx_ttl);
        end
        if (o_tx_checksum !== 16'h0) begin
            report_mismatch(test, "checksum", 0, o_tx_checksum);
        end
        @(negedge clk);
        i_tx_hdr_ready = 1'b0;
        for (int i = 0; i < payload_len; i++) begin
            done = 1'b0;
            while (!done) begin
                @(negedge clk);
                i_tx_tready = next_ready(stall);
                @(posedge clk);
                done = o_tx_tvalid && i_tx_tready;
            end
            if (o_tx_tdata !== payload[i]) begin
                report_mismatch(test, "tdata", payload[i], o_tx_tdata);
            end
            if (o_tx_tuser !== payload_user[i]) begin
                report_mismatch(test, "tuser", payload_user[i], o_tx_tuser);
            end
            if (o_tx_tlast !== (i == payload_len - 1)) begin
                report_mismatch(test, "tlast", 32'(i == payload_len - 1), o_tx_tlast);
            end
        end
        @(negedge clk);
        i_tx_tready = 1'b0;
        @(posedge clk);
        if (o_tx_hdr_valid !== 1'b0) begin
            $display("ERROR %s: a second reply header appeared", test);
            errors++;
        end
        if (o_tx_tvalid !== 1'b0) begin
            $display("ERROR %s: payload bytes left over after the last one", test);
            errors++;
        end
    endtask

    // Nothing may come out for a dropped frame even with both readies high
    task automatic check_no_reply(input string test);
        bit seen;
        seen = 1'b0;
        @(negedge clk);
        i_tx_hdr_ready = 1'b1;
        i_tx_tready    = 1'b1;
        repeat (40) begin
            @(posedge clk);
            if (o_tx_hdr_valid || o_tx_tvalid) seen = 1'b1;
        end
        if (seen) begin
            $display("ERROR %s: reply header or payload seen for a dropped frame", test);
            errors++;
        end
        if (o_rx_hdr_ready !== 1'b1) begin
            $display("ERROR %s: filter did not return to idle after the frame", test);
            errors++;
        end
        @(negedge clk);
        i_tx_hdr_ready = 1'b0;
        i_tx_tready    = 1'b0;
    endtask

    task automatic run_udp_frame(input string test, input udp_port_t dst_port,
                                 input bit echoed, input bit stall);
        ip_addr_t    src_ip;
        udp_port_t   src_port;
        logic [15:0] length;
        src_ip      = ip_addr_t'($urandom);
        src_port    = udp_port_t'($urandom_range(1024, 65535));
        payload_len = $urandom_range(5, MAX_PAYLOAD);
        length      = 16'(payload_len + 8);
        for (int i = 0; i < payload_len; i++) begin
            payload[i]      = byte_t'($urandom);
            payload_user[i] = 1'($urandom_range(0, 1));
        end
        send_header(src_ip, src_port, dst_port, length);
        send_payload();
        if (echoed) begin
            collect_reply(test, src_ip, src_port, length, stall);
            led_expected = payload[0];
        end else begin
            check_no_reply(test);
        end
        if (o_led !== led_expected) report_mismatch(test, "o_led", led_expected, o_led);
    endtask

    initial begin
        udp_port_t other_port;
        void'($urandom(32'h2067));
        clk            = 1'b0;
        rst            = 1'b1;
        i_uart_rxd     = 1'b1;
        i_rx_hdr_valid = 1'b0;
        i_rx_src_ip    = '0;
        i_rx_dst_ip    = '0;
        i_rx_src_port  = '0;
        i_rx_dst_port  = '0;
        i_rx_length    = '0;
        i_rx_tdata     = '0;
        i_rx_tvalid    = 1'b0;
        i_rx_tlast     = 1'b0;
        i_rx_tuser     = 1'b0;
        i_tx_hdr_ready = 1'b0;
        i_tx_tready    = 1'b0;
        errors         = 0;
        cycle_cnt      = 0;
        stall_cnt      = 0;
        led_expected   = 8'h00;

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        check_reset_state();
        test_uart_echo();
        run_udp_frame("matching_frame", EXP_ECHO_PORT, 1'b1, 1'b0);
        other_port = udp_port_t'($urandom_range(1235, 65535));
        run_udp_frame("dropped_frame", other_port, 1'b0, 1'b0);
        run_udp_frame("after_drop", EXP_ECHO_PORT, 1'b1, 1'b0);
        run_udp_frame("back_pressure_1", EXP_ECHO_PORT, 1'b1, 1'b1);
        run_udp_frame("back_pressure_2", EXP_ECHO_PORT, 1'b1, 1'b1);

        $display("Tests done after %0d cycles: %0d errors", cycle_cnt, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
src/udp_echo_pkg.sv
src/byte_stream_if.sv
src/byte_fifo.sv
src/uart_rx.sv
src/uart_tx.sv
src/udp_port_filter.sv
src/udp_echo_path.sv
src/echo_core.sv
testbench/tb_echo_core.sv

/* Bender.yml */
package:
  name: echo_core

sources:
  - src/udp_echo_pkg.sv
  - src/byte_stream_if.sv
  - src/byte_fifo.sv
  - src/uart_rx.sv
  - src/uart_tx.sv
  - src/udp_port_filter.sv
  - src/udp_echo_path.sv
  - src/echo_core.sv
  - target: test
    files:
      - testbench/tb_echo_core.sv
